/* Makefile */
# Verilator build and run of the mcoi application testbench
# override any variable on the command line, e.g. make run LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mcoi_app
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard rtl/*.sv rtl/*.svh test/*.sv test/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q -F '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
+incdir+rtl
+incdir+test
rtl/mcoi_pkg.sv
rtl/ps_record_if.sv
rtl/ps_buffer_reader.sv
rtl/ps_register_demux.sv
rtl/motor_io.sv
rtl/readback_mux.sv
rtl/mcoi_app_top.sv
test/tb_mcoi_app.sv

/* rtl/mcoi_app_top.sv */
//----------------------------------------------------------
// mcoi application top
// slow-control core in the gbt receive clock domain:
// board data import, motor interlock, status and readback
//----------------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

`include "mcoi_consts.svh"

module mcoi_app_top (
   input  logic                       gbt_rx_clkrs,
   input  logic                       rst_i,
   // processor shared buffer
   input  logic                       ps_start_i,
   input  logic [31:0]                ps_dout_i,
   output logic [`MCOI_PS_ADDR_W-1:0] ps_addr_o,
   output logic                       ps_progress_o,
   // link words
   input  logic [63:0]                motor_data_i,
   input  logic [31:0]                feedback_i,
   input  logic [31:0]                page_i,
   input  logic                       page_strobe_i,
   input  logic                       rx_clken_i,
   // board pins
   input  logic [`MCOI_MOTORS-1:0]    pfail_n_i,
   input  logic [`MCOI_MOTORS-1:0]    sw_outa_n_i,
   input  logic [`MCOI_MOTORS-1:0]    sw_outb_n_i,
   input  logic [3:0]                 pcb_rev_i,
   input  logic                       rs485_ro_i,
   output logic [`MCOI_MOTORS-1:0]    boost_o,
   output logic [`MCOI_MOTORS-1:0]    dir_o,
   output logic [`MCOI_MOTORS-1:0]    en_o,
   output logic [`MCOI_MOTORS-1:0]    step_o,
   output logic                       link_closed_o,
   output logic [63:0]                link_status_o,
   output logic [31:0]                readback_o,
   output logic                       rs485_di_o
);

   logic [127:0]                               uid;
   logic [31:0]                                power;
   logic [31:0]                                temp;
   mcoi_pkg::motor_status_t [`MCOI_MOTORS-1:0] motor_status;

   ps_record_if rec_if ();

   // processor sees progress to know when the buffer is free
   assign ps_progress_o = rec_if.progress;
   // synchronized status goes back on the link unchanged
   assign link_status_o = motor_status;

   ps_buffer_reader i_ps_buffer_reader (
      .gbt_rx_clkrs, .rst_i, .ps_start_i, .ps_dout_i, .ps_addr_o,
      .rec          (rec_if.reader)
   );

   ps_register_demux i_ps_register_demux (
      .gbt_rx_clkrs, .rst_i,
      .rec          (rec_if.demux),
      .uid_o        (uid),
      .power_o      (power),
      .temp_o       (temp)
   );

   motor_io i_motor_io (
      .gbt_rx_clkrs, .rst_i, .motor_data_i, .feedback_i,
      .page_hold_i  (page_i[31]),
      .pfail_n_i, .sw_outa_n_i, .sw_outb_n_i,
      .boost_o, .dir_o, .en_o, .step_o,
      .status_o     (motor_status),
      .link_closed_o
   );

   readback_mux i_readback_mux (
      .gbt_rx_clkrs, .rst_i, .page_i, .page_strobe_i, .rx_clken_i,
      .uid_i        (uid),
      .power_i      (power),
      .temp_i       (temp),
      .pcb_rev_i, .rs485_ro_i,
      .status_i     (motor_status),
      .readback_o, .rs485_di_o
   );

endmodule

`default_nettype wire

/* rtl/mcoi_consts.svh */
//----------------------------------------------------------
// mcoi constants
// sizes, record ids and fixed words shared by the
// slow-control core of the motor controller
//----------------------------------------------------------

`ifndef MCOI_CONSTS_SVH
`define MCOI_CONSTS_SVH

// motors served by one fiber
`define MCOI_MOTORS 16
// shared buffer address width, address 0 is reserved
`define MCOI_PS_ADDR_W 8

// record ids of the unique id words, low word first
// id 3 is not used by the processor
`define MCOI_ID_UID0 8'd1
`define MCOI_ID_UID1 8'd2
`define MCOI_ID_UID2 8'd4
`define MCOI_ID_UID3 8'd5
`define MCOI_ID_UID4 8'd6
`define MCOI_ID_UID5 8'd7
`define MCOI_ID_UID6 8'd8
`define MCOI_ID_UID7 8'd9
`define MCOI_ID_POWER 8'd10
`define MCOI_ID_TEMP 8'd13

// feedback word that closes the motor interlock
`define MCOI_INTERLOCK_KEY 32'h5A5A_C3C3
`define MCOI_BUILD_NUMBER 32'h0002_0117
// readback of pages without a meaning
`define MCOI_FILLER 32'hDEAD_BEEF
`define MCOI_SYNC_STAGES 3

`endif

/* rtl/mcoi_pkg.sv */
//----------------------------------------------------------
// mcoi types
// state and page encodings plus per-motor control and
// status nibbles as they travel on the link
//----------------------------------------------------------

`default_nettype none

package mcoi_pkg;

   // buffer scan state machine
   typedef enum logic [1:0] {
      WAIT_FOR_START,
      READ_ALL_DATA,
      FINISHED
   } reader_state_e;

   // readback pages, low byte of the page selector
   typedef enum logic [7:0] {
      PAGE_LOOPBACK    = 8'd0,
      PAGE_BUILD       = 8'd1,
      PAGE_PCB_REV     = 8'd2,
      PAGE_UID_HI      = 8'd3,
      PAGE_UID_LO      = 8'd4,
      PAGE_TEMP        = 8'd5,
      PAGE_POWER       = 8'd6,
      PAGE_ONE         = 8'd7,
      PAGE_RS485       = 8'd8,
      PAGE_MOTOR_FIRST = 8'd16
   } readback_page_e;

   // one motor command nibble, msb first
   typedef struct packed {
      logic boost;
      logic dir;
      logic deactivate;
      logic step;
   } motor_ctrl_t;

   // one motor status nibble, all active high
   typedef struct packed {
      logic pfail;
      logic switch_b;
      logic switch_a;
      logic overheat;
   } motor_status_t;

endpackage

`default_nettype wire

/* rtl/motor_io.sv */
//----------------------------------------------------------
// motor io
// interlocked stepper command path and synchronized driver
// status path back towards the link
//----------------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

`include "mcoi_consts.svh"

module motor_io (
   input  logic                                       gbt_rx_clkrs,
   input  logic                                       rst_i,
   input  mcoi_pkg::motor_ctrl_t   [`MCOI_MOTORS-1:0] motor_data_i,
   input  logic [31:0]                                feedback_i,
   input  logic                                       page_hold_i,
   input  logic [`MCOI_MOTORS-1:0]                    pfail_n_i,
   input  logic [`MCOI_MOTORS-1:0]                    sw_outa_n_i,
   input  logic [`MCOI_MOTORS-1:0]                    sw_outb_n_i,
   output logic [`MCOI_MOTORS-1:0]                    boost_o,
   output logic [`MCOI_MOTORS-1:0]                    dir_o,
   output logic [`MCOI_MOTORS-1:0]                    en_o,
   output logic [`MCOI_MOTORS-1:0]                    step_o,
   output mcoi_pkg::motor_status_t [`MCOI_MOTORS-1:0] status_o,
   output logic                                       link_closed_o
);

   logic                                       key_match;
   logic                                       link_closed_q;
   mcoi_pkg::motor_ctrl_t   [`MCOI_MOTORS-1:0] ctrl_q;
   mcoi_pkg::motor_status_t [`MCOI_MOTORS-1:0] status_raw;
   mcoi_pkg::motor_status_t [`MCOI_MOTORS-1:0] sync_q [`MCOI_SYNC_STAGES];

   assign key_match = (feedback_i == `MCOI_INTERLOCK_KEY);

   //----------------------------------------------------------
   // interlock
   //----------------------------------------------------------
   // all ones means every driver deactivated, safe default
   // until the loop is closed
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i || !key_match) begin
         ctrl_q <= '1;
      end else begin
         ctrl_q <= motor_data_i;
      end
   end

   // page bit 31 lets the host hold the link indicator off
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         link_closed_q <= 1'b0;
      end else begin
         link_closed_q <= key_match && !page_hold_i;
      end
   end

   assign link_closed_o = link_closed_q;

   // pin mapping and status inversion per motor
   for (genvar m = 0; m < `MCOI_MOTORS; m++) begin : g_motor
      assign boost_o[m] = ctrl_q[m].boost;
      assign dir_o[m]   = ctrl_q[m].dir;
      // driver enable pin is active low, fed by deactivate
      assign en_o[m]    = ctrl_q[m].deactivate;
      assign step_o[m]  = ctrl_q[m].step;

      assign status_raw[m].pfail    = ~pfail_n_i[m];
      assign status_raw[m].switch_b = ~sw_outb_n_i[m];
      assign status_raw[m].switch_a = ~sw_outa_n_i[m];
      // overheat line not wired on this board
      assign status_raw[m].overheat = 1'b0;
   end

   // driver pins are asynchronous to the link clock
   always_ff @(posedge gbt_rx_clkrs) begin
      sync_q[0] <= status_raw;
      for (int i = 1; i < `MCOI_SYNC_STAGES; i++) begin
         sync_q[i] <= sync_q[i-1];
      end
   end

   assign status_o = sync_q[`MCOI_SYNC_STAGES-1];

   // an open loop must park every motor on the next edge
   a_open_loop_safe : assert property (@(posedge gbt_rx_clkrs) disable iff (rst_i)
      !key_match |=> (&{boost_o, dir_o, en_o, step_o}));

endmodule

`default_nettype wire

/* rtl/ps_buffer_reader.sv */
//----------------------------------------------------------
// ps buffer reader
// on a start request walks the whole processor buffer and
// emits one record per word, progress flags the scan
//----------------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

`include "mcoi_consts.svh"

module ps_buffer_reader (
   input  logic                       gbt_rx_clkrs,
   input  logic                       rst_i,
   input  logic                       ps_start_i,
   input  logic [31:0]                ps_dout_i,
   output logic [`MCOI_PS_ADDR_W-1:0] ps_addr_o,
   ps_record_if.reader                rec
);

   mcoi_pkg::reader_state_e    state_q;
   logic [`MCOI_PS_ADDR_W-1:0] addr_q;

   // buffer answers combinationally on this address
   assign ps_addr_o = addr_q;

   //----------------------------------------------------------
   // scan control
   //----------------------------------------------------------
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         state_q       <= mcoi_pkg::WAIT_FOR_START;
         addr_q        <= '0;
         rec.progress  <= 1'b0;
         rec.rec_valid <= 1'b0;
      end else begin
         // a record follows every address presented in the scan
         rec.rec_valid <= 1'b0;
         case (state_q)
            mcoi_pkg::WAIT_FOR_START: begin
               // progress also covers the cycle after FINISHED
               rec.progress <= ps_start_i;
               if (ps_start_i) begin
                  // address 0 is reserved, start at 1
                  addr_q  <= `MCOI_PS_ADDR_W'(1);
                  state_q <= mcoi_pkg::READ_ALL_DATA;
               end
            end
            mcoi_pkg::READ_ALL_DATA: begin
               rec.rec_valid <= 1'b1;
               addr_q        <= addr_q + `MCOI_PS_ADDR_W'(1);
               // last address, counter wraps back to 0
               if (&addr_q) begin
                  state_q <= mcoi_pkg::FINISHED;
               end
            end
            mcoi_pkg::FINISHED: begin
               // last record is on the channel now
               state_q <= mcoi_pkg::WAIT_FOR_START;
            end
            default: begin
               state_q <= mcoi_pkg::WAIT_FOR_START;
            end
         endcase
      end
   end

   // word layout is id, reserved byte, value
   always_ff @(posedge gbt_rx_clkrs) begin
      rec.rec_id    <= ps_dout_i[31:24];
      rec.rec_value <= ps_dout_i[15:0];
   end

   // a scan can only be launched from the idle state
   a_progress_rise : assert property (@(posedge gbt_rx_clkrs) disable iff (rst_i)
      $rose(rec.progress) |-> $past(state_q) == mcoi_pkg::WAIT_FOR_START);

   // records never leak out while idle
   a_idle_no_record : assert property (@(posedge gbt_rx_clkrs) disable iff (rst_i)
      state_q == mcoi_pkg::WAIT_FOR_START |-> !rec.rec_valid);

endmodule

`default_nettype wire

/* rtl/ps_record_if.sv */
//----------------------------------------------------------
// buffer record channel
// carries id/value records from the buffer reader to the
// register demux, no back-pressure
//----------------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

interface ps_record_if;

   // record present this cycle, consumed in the same cycle
   logic        rec_valid;
   logic [7:0]  rec_id;
   logic [15:0] rec_value;
   // high for the whole scan
   logic        progress;

   modport reader (output rec_valid, output rec_id, output rec_value, output progress);

   modport demux (input rec_valid, input rec_id, input rec_value, input progress);

endinterface

`default_nettype wire

/* rtl/ps_register_demux.sv */
//----------------------------------------------------------
// ps register demux
// routes buffer records by id into unique id, power and
// temperature registers, publishes them between scans
//----------------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

`include "mcoi_consts.svh"

module ps_register_demux (
   input  logic          gbt_rx_clkrs,
   input  logic          rst_i,
   ps_record_if.demux    rec,
   output logic [127:0]  uid_o,
   output logic [31:0]   power_o,
   output logic [31:0]   temp_o
);

   // working registers, filled during the scan
   logic [7:0][15:0] uid_q;
   logic [15:0]      power_q;
   logic [15:0]      temp_q;

   // published copy, frozen while a scan runs
   logic [7:0][15:0] uid_pub_q;
   logic [15:0]      power_pub_q;
   logic [15:0]      temp_pub_q;

   //----------------------------------------------------------
   // id demux
   //----------------------------------------------------------
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         uid_q   <= '0;
         power_q <= '0;
         temp_q  <= '0;
      end else if (rec.rec_valid) begin
         // unknown ids fall through untouched
         case (rec.rec_id)
            `MCOI_ID_UID0:  uid_q[0] <= rec.rec_value;
            `MCOI_ID_UID1:  uid_q[1] <= rec.rec_value;
            `MCOI_ID_UID2:  uid_q[2] <= rec.rec_value;
            `MCOI_ID_UID3:  uid_q[3] <= rec.rec_value;
            `MCOI_ID_UID4:  uid_q[4] <= rec.rec_value;
            `MCOI_ID_UID5:  uid_q[5] <= rec.rec_value;
            `MCOI_ID_UID6:  uid_q[6] <= rec.rec_value;
            `MCOI_ID_UID7:  uid_q[7] <= rec.rec_value;
            `MCOI_ID_POWER: power_q  <= rec.rec_value;
            `MCOI_ID_TEMP:  temp_q   <= rec.rec_value;
            default: ;
         endcase
      end
   end

   //----------------------------------------------------------
   // snapshot
   //----------------------------------------------------------
   // copy only while idle so readback never sees a half scan
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         uid_pub_q   <= '0;
         power_pub_q <= '0;
         temp_pub_q  <= '0;
      end else if (!rec.progress) begin
         uid_pub_q   <= uid_q;
         power_pub_q <= power_q;
         temp_pub_q  <= temp_q;
      end
   end

   assign uid_o   = uid_pub_q;
   // upper halves carry nothing yet
   assign power_o = {16'b0, power_pub_q};
   assign temp_o  = {16'b0, temp_pub_q};

endmodule

`default_nettype wire

/* rtl/readback_mux.sv */
//----------------------------------------------------------
// readback mux
// loopback word and page selected register fed back on
// the serial return path
//----------------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

`include "mcoi_consts.svh"

module readback_mux (
   input  logic                                       gbt_rx_clkrs,
   input  logic                                       rst_i,
   input  logic [31:0]                                page_i,
   input  logic                                       page_strobe_i,
   input  logic                                       rx_clken_i,
   input  logic [127:0]                               uid_i,
   input  logic [31:0]                                power_i,
   input  logic [31:0]                                temp_i,
   input  logic [3:0]                                 pcb_rev_i,
   input  logic                                       rs485_ro_i,
   input  mcoi_pkg::motor_status_t [`MCOI_MOTORS-1:0] status_i,
   output logic [31:0]                                readback_o,
   output logic                                       rs485_di_o
);

   localparam int SEL_W = $clog2(`MCOI_MOTORS);

   logic [31:0] loopback_q;
   logic [31:0] readback_q;
   logic [7:0]  page_num;
   logic [7:0]  motor_sel;
   logic        motor_page;

   // motor pages start at PAGE_MOTOR_FIRST, one per motor
   assign page_num   = page_i[7:0];
   assign motor_sel  = page_num - 8'(mcoi_pkg::PAGE_MOTOR_FIRST);
   assign motor_page = (page_num >= 8'(mcoi_pkg::PAGE_MOTOR_FIRST)) &&
                       (motor_sel < 8'(`MCOI_MOTORS));

   // echo of the host hold bit, bit 0 marks a live link
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         loopback_q <= 32'd1;
      end else if (page_strobe_i) begin
         loopback_q <= {page_i[31], 30'b0, 1'b1};
      end
   end

   // sampled only on the link clock enable
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         readback_q <= '0;
      end else if (rx_clken_i) begin
         case (mcoi_pkg::readback_page_e'(page_num))
            mcoi_pkg::PAGE_LOOPBACK: readback_q <= loopback_q;
            mcoi_pkg::PAGE_BUILD:    readback_q <= `MCOI_BUILD_NUMBER;
            mcoi_pkg::PAGE_PCB_REV:  readback_q <= {28'b0, pcb_rev_i};
            mcoi_pkg::PAGE_UID_HI:   readback_q <= uid_i[63:32];
            mcoi_pkg::PAGE_UID_LO:   readback_q <= uid_i[31:0];
            mcoi_pkg::PAGE_TEMP:     readback_q <= temp_i;
            mcoi_pkg::PAGE_POWER:    readback_q <= power_i;
            mcoi_pkg::PAGE_ONE:      readback_q <= 32'd1;
            mcoi_pkg::PAGE_RS485:    readback_q <= {31'b0, rs485_ro_i};
            default: begin
               // per-motor status nibble or filler
               if (motor_page) begin
                  readback_q <= {28'b0, status_i[motor_sel[SEL_W-1:0]]};
               end else begin
                  readback_q <= `MCOI_FILLER;
               end
            end
         endcase
      end
   end

   assign readback_o = readback_q;
   // driver programming line straight from the selector
   assign rs485_di_o = page_i[30];

endmodule

`default_nettype wire

/* test/tb_mcoi_model.svh */
//----------------------------------------------------------
// reference model of the slow-control core
// buffer contents, id map, interlock rule and page table
//----------------------------------------------------------

`ifndef TB_MCOI_MODEL_SVH
`define TB_MCOI_MODEL_SVH

localparam int BUF_WORDS = 1 << `MCOI_PS_ADDR_W;

// processor buffer, answered combinationally
logic [31:0] buf_mem [BUF_WORDS];
// expected board registers: uid words 0 to 7, power, temp
logic [15:0] board_m [10];
logic [31:0] loopback_m;
logic [63:0] status_m;

// known ids in register slot order
function automatic logic [7:0] known_id(input int idx);
   case (idx)
      0: return `MCOI_ID_UID0;
      1: return `MCOI_ID_UID1;
      2: return `MCOI_ID_UID2;
      3: return `MCOI_ID_UID3;
      4: return `MCOI_ID_UID4;
      5: return `MCOI_ID_UID5;
      6: return `MCOI_ID_UID6;
      7: return `MCOI_ID_UID7;
      8: return `MCOI_ID_POWER;
      default: return `MCOI_ID_TEMP;
   endcase
endfunction

// register slot of a record id, -1 when unknown
function automatic int id_slot(input logic [7:0] id);
   for (int i = 0; i < 10; i++) begin
      if (known_id(i) == id) begin
         return i;
      end
   end
   return -1;
endfunction

// addresses from 1 upwards, a later record overwrites an earlier one
task automatic model_scan();
   int slot;
   for (int a = 1; a < BUF_WORDS; a++) begin
      slot = id_slot(buf_mem[a][31:24]);
      if (slot >= 0) begin
         board_m[slot] = buf_mem[a][15:0];
      end
   end
endtask

// open loop parks every motor with all bits at one
function automatic logic [63:0] interlock_ctrl(input logic [63:0] data, input logic [31:0] fb);
   return (fb == `MCOI_INTERLOCK_KEY) ? data : {64{1'b1}};
endfunction

// one field of every nibble: 3 boost, 2 dir, 1 deactivate, 0 step
function automatic logic [15:0] ctrl_field(input logic [63:0] ctrl, input int pos);
   logic [15:0] f;
   for (int m = 0; m < `MCOI_MOTORS; m++) begin
      f[m] = ctrl[4*m + pos];
   end
   return f;
endfunction

// nibble is pfail, switch b, switch a, overheat, all active high
function automatic logic [63:0] status_word(input logic [15:0] pf_n, input logic [15:0] a_n,
                                            input logic [15:0] b_n);
   logic [63:0] w;
   for (int m = 0; m < `MCOI_MOTORS; m++) begin
      w[4*m +: 4] = {~pf_n[m], ~b_n[m], ~a_n[m], 1'b0};
   end
   return w;
endfunction

// expected readback word of a page
function automatic logic [31:0] page_word(input logic [31:0] page);
   int p;
   p = int'(page[7:0]);
   case (p)
      0: return loopback_m;
      1: return `MCOI_BUILD_NUMBER;
      2: return {28'b0, pcb_rev_i};
      3: return {board_m[3], board_m[2]};
      4: return {board_m[1], board_m[0]};
      5: return {16'b0, board_m[9]};
      6: return {16'b0, board_m[8]};
      7: return 32'd1;
      8: return {31'b0, rs485_ro_i};
      default: ;
   endcase
   if (p >= 16 && p < 16 + `MCOI_MOTORS) begin
      return {28'b0, status_m[4*(p-16) +: 4]};
   end
   return `MCOI_FILLER;
endfunction

`endif

/* test/tb_mcoi_app.sv */
//----------------------------------------------------------
// testbench for the mcoi application top
// random link words, pins and buffer contents checked
// against the reference model
//----------------------------------------------------------

`default_nettype none
`timescale 1ns/10ps

`include "mcoi_consts.svh"

module tb_mcoi_app;

   localparam int CLK_PERIOD       = 20;
   localparam int RESET_CYCLES     = 8;
   localparam int INTERLOCK_CYCLES = 200;
   localparam int STATUS_ROUNDS    = 8;
   localparam int SCAN_PASSES      = 2;
   localparam int SCAN_LIMIT       = 400;
   localparam int FILLER_TRIES     = 24;
   // summed test lengths in cycles
   localparam int RUN_CYCLES = RESET_CYCLES + 4 + INTERLOCK_CYCLES
      + STATUS_ROUNDS * (3 + `MCOI_MOTORS) + SCAN_PASSES * (SCAN_LIMIT + 8)
      + FILLER_TRIES + 16;
   localparam int TIMEOUT_NS = (RUN_CYCLES + 200) * CLK_PERIOD;

   logic                       gbt_rx_clkrs;
   logic                       rst_i;
   logic                       ps_start_i;
   logic [31:0]                ps_dout_i;
   logic [`MCOI_PS_ADDR_W-1:0] ps_addr_o;
   logic                       ps_progress_o;
   logic [63:0]                motor_data_i;
   logic [31:0]                feedback_i;
   logic [31:0]                page_i;
   logic                       page_strobe_i;
   logic                       rx_clken_i;
   logic [`MCOI_MOTORS-1:0]    pfail_n_i;
   logic [`MCOI_MOTORS-1:0]    sw_outa_n_i;
   logic [`MCOI_MOTORS-1:0]    sw_outb_n_i;
   logic [3:0]                 pcb_rev_i;
   logic                       rs485_ro_i;
   logic [`MCOI_MOTORS-1:0]    boost_o;
   logic [`MCOI_MOTORS-1:0]    dir_o;
   logic [`MCOI_MOTORS-1:0]    en_o;
   logic [`MCOI_MOTORS-1:0]    step_o;
   logic                       link_closed_o;
   logic [63:0]                link_status_o;
   logic [31:0]                readback_o;
   logic                       rs485_di_o;

   int          errors;
   int          tests_failed;

   `include "tb_mcoi_model.svh"

   // buffer read is combinational
   assign ps_dout_i = buf_mem[ps_addr_o];

   mcoi_app_top i_mcoi_app_top (.*);

   always #(CLK_PERIOD / 2) gbt_rx_clkrs = ~gbt_rx_clkrs;

   // watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired after %0d ns, run stopped", TIMEOUT_NS);
      $display(">>> FAIL");
      $finish;
   end

   // inputs change 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge gbt_rx_clkrs);
      #1;
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                  input logic [63:0] act_val);
      errors++;
      $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp_val, act_val);
   endtask

   task automatic end_test(input string name, input int err_before);
      if (errors == err_before) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - err_before);
      end
   endtask

   // readback is valid one edge after the page is driven
   task automatic check_page(input logic [31:0] page);
      logic [31:0] exp_val;
      page_i = page;
      next_cycle();
      exp_val = page_word(page);
      if (readback_o !== exp_val) begin
         report_mismatch($sformatf("readback_o page %0d", page[7:0]), 64'(exp_val),
                         64'(readback_o));
      end
   endtask

   //----------------------------------------------------------
   // tests
   //----------------------------------------------------------
   task automatic test_reset();
      int err_before;
      err_before = errors;
      if (ps_progress_o !== 1'b0) report_mismatch("ps_progress_o", 64'(0), 64'(ps_progress_o));
      if (ps_addr_o !== '0) report_mismatch("ps_addr_o", 64'(0), 64'(ps_addr_o));
      if (readback_o !== '0) report_mismatch("readback_o", 64'(0), 64'(readback_o));
      if (link_closed_o !== 1'b0) report_mismatch("link_closed_o", 64'(0), 64'(link_closed_o));
      if ({boost_o, dir_o, en_o, step_o} !== {64{1'b1}}) begin
         report_mismatch("motor pins", {64{1'b1}}, {boost_o, dir_o, en_o, step_o});
      end
      page_i = 32'd0;
      next_cycle();
      next_cycle();
      if (readback_o !== page_word(32'd0)) begin
         report_mismatch("readback_o page 0", 64'(page_word(32'd0)), 64'(readback_o));
      end
      end_test("reset", err_before);
   endtask

   task automatic test_interlock();
      int          err_before;
      logic [63:0] data;
      logic [63:0] ctrl;
      logic [31:0] fb;
      logic        hold;
      err_before = errors;
      for (int i = 0; i < INTERLOCK_CYCLES; i++) begin
         data = {$urandom, $urandom};
         fb   = ($urandom_range(0, 1) == 1) ? `MCOI_INTERLOCK_KEY : $urandom;
         hold = 1'($urandom_range(0, 1));
         motor_data_i = data;
         feedback_i   = fb;
         page_i       = {hold, 31'b0};
         next_cycle();
         ctrl = interlock_ctrl(data, fb);
         if (boost_o !== ctrl_field(ctrl, 3)) begin
            report_mismatch("boost_o", 64'(ctrl_field(ctrl, 3)), 64'(boost_o));
         end
         if (dir_o !== ctrl_field(ctrl, 2)) begin
            report_mismatch("dir_o", 64'(ctrl_field(ctrl, 2)), 64'(dir_o));
         end
         if (en_o !== ctrl_field(ctrl, 1)) begin
            report_mismatch("en_o", 64'(ctrl_field(ctrl, 1)), 64'(en_o));
         end
         if (step_o !== ctrl_field(ctrl, 0)) begin
            report_mismatch("step_o", 64'(ctrl_field(ctrl, 0)), 64'(step_o));
         end
         if (link_closed_o !== ((fb == `MCOI_INTERLOCK_KEY) && !hold)) begin
            report_mismatch("link_closed_o", 64'((fb == `MCOI_INTERLOCK_KEY) && !hold),
                            64'(link_closed_o));
         end
      end
      page_i = 32'd0;
      end_test("interlock", err_before);
   endtask

   task automatic test_status();
      int          err_before;
      logic [63:0] prev;
      logic [63:0] exp_new;
      err_before = errors;
      for (int r = 0; r < STATUS_ROUNDS; r++) begin
         prev        = status_m;
         pfail_n_i   = 16'($urandom);
         sw_outa_n_i = 16'($urandom);
         sw_outb_n_i = 16'($urandom);
         exp_new     = status_word(pfail_n_i, sw_outa_n_i, sw_outb_n_i);
         next_cycle();
         next_cycle();
         // still the old pattern one edge before the third stage
         if (link_status_o !== prev) begin
            report_mismatch("link_status_o early", prev, link_status_o);
         end
         next_cycle();
         if (link_status_o !== exp_new) report_mismatch("link_status_o", exp_new, link_status_o);
         status_m = exp_new;
         for (int m = 0; m < `MCOI_MOTORS; m++) begin
            check_page({24'b0, 8'(16 + m)});
         end
      end
      end_test("status", err_before);
   endtask

   task automatic test_scan();
      int         err_before;
      int         high_cycles;
      logic [7:0] id;
      err_before = errors;
      for (int pass = 0; pass < SCAN_PASSES; pass++) begin
         for (int a = 0; a < BUF_WORDS; a++) begin
            if ($urandom_range(0, 3) == 0) begin
               id = 8'($urandom_range(0, 255));
            end else if (pass == 0) begin
               id = known_id(int'($urandom_range(0, 9)));
            end else begin
               // mostly even slots so the odd ones keep the first pass values
               id = known_id(2 * int'($urandom_range(0, 4)));
            end
            buf_mem[a] = {id, 8'($urandom), 16'($urandom)};
         end
         model_scan();
         ps_start_i = 1'b1;
         next_cycle();
         ps_start_i  = 1'b0;
         high_cycles = 0;
         while (ps_progress_o && high_cycles < SCAN_LIMIT) begin
            high_cycles++;
            next_cycle();
         end
         if (ps_progress_o) begin
            errors++;
            $display("buffer scan did not finish within %0d cycles", SCAN_LIMIT);
         end else if (high_cycles != BUF_WORDS + 1) begin
            report_mismatch("ps_progress_o high cycles", 64'(BUF_WORDS + 1), 64'(high_cycles));
         end
         // snapshot copies on the first idle edge
         next_cycle();
         for (int p = 3; p <= 6; p++) begin
            check_page({24'b0, 8'(p)});
         end
      end
      end_test("buffer scan", err_before);
   endtask

   task automatic test_fixed_pages();
      int          err_before;
      logic [7:0]  p;
      logic [31:0] page;
      err_before = errors;
      check_page(32'd1);
      check_page(32'd2);
      check_page(32'd7);
      rs485_ro_i = 1'b1;
      check_page(32'd8);
      rs485_ro_i = 1'b0;
      check_page(32'd8);
      // loopback echoes bit 31 of the strobed page
      for (int k = 1; k >= 0; k--) begin
         page_i        = {1'(k), 31'b0};
         page_strobe_i = 1'b1;
         next_cycle();
         page_strobe_i = 1'b0;
         loopback_m    = {1'(k), 30'b0, 1'b1};
         check_page({1'(k), 31'b0});
      end
      for (int i = 0; i < FILLER_TRIES; i++) begin
         p = 8'($urandom_range(9, 255));
         if (p >= 8'd16 && p < 8'(16 + `MCOI_MOTORS)) begin
            p = p + 8'(`MCOI_MOTORS);
         end
         page = {24'($urandom), p};
         check_page(page);
         if (rs485_di_o !== page[30]) begin
            report_mismatch("rs485_di_o", 64'(page[30]), 64'(rs485_di_o));
         end
      end
      end_test("fixed pages", err_before);
   endtask

   //----------------------------------------------------------
   // main sequence
   //----------------------------------------------------------
   initial begin
      void'($urandom(43));
      errors        = 0;
      tests_failed  = 0;
      gbt_rx_clkrs  = 1'b0;
      rst_i         = 1'b1;
      ps_start_i    = 1'b0;
      motor_data_i  = '0;
      feedback_i    = '0;
      page_i        = '0;
      page_strobe_i = 1'b0;
      rx_clken_i    = 1'b1;
      // driver pins idle high with no fault
      pfail_n_i     = '1;
      sw_outa_n_i   = '1;
      sw_outb_n_i   = '1;
      pcb_rev_i     = 4'($urandom);
      rs485_ro_i    = 1'b0;
      for (int a = 0; a < BUF_WORDS; a++) begin
         buf_mem[a] = '0;
      end
      for (int s = 0; s < 10; s++) begin
         board_m[s] = '0;
      end
      loopback_m = 32'd1;
      status_m   = '0;
      repeat (RESET_CYCLES) next_cycle();
      rst_i = 1'b0;
      test_reset();
      test_interlock();
      test_status();
      test_scan();
      test_fixed_pages();
      $display("tests 5, failed %0d, errors %0d", tests_failed, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
